/* verilog/pipeline_consts.svh */
`ifndef PIPELINE_CONSTS_SVH
`define PIPELINE_CONSTS_SVH

`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5

// word address of the data memory is taken from byte address bits 9 down to 2.
`define DMEM_ADDR_WIDTH 8
`define DMEM_DEPTH (1 << `DMEM_ADDR_WIDTH)

`endif

/* verilog/pipelinePkg.sv */
package pipelinePkg;

    // operation performed by the execute stage ALU.
    typedef enum logic [2:0]
    {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5, // signed compare, result is 0 or 1.
        ALU_SLL = 3'd6  // shift amount is the low 5 bits of operand B.
    } aluOp_t;

    // source of the value written back to the register file.
    typedef enum logic [1:0]
    {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2   // link value for jump-and-link.
    } wbSource_t;

endpackage

/* verilog/executeStage.sv */
`timescale 1ns/1ps
`include "pipeline_consts.svh"

module executeStage
(
    input  logic [`DATA_WIDTH-1:0] readData1,
    input  logic [`DATA_WIDTH-1:0] readData2,
    input  logic [`DATA_WIDTH-1:0] immediate,
    input  logic [`DATA_WIDTH-1:0] pc4,
    input  logic [`DATA_WIDTH-1:0] jumpTarget,
    input  logic                   ctrlAluSrc,
    input  logic                   ctrlBranch,
    input  logic                   ctrlJump,
    input  pipelinePkg::aluOp_t    aluOp,
    output logic [`DATA_WIDTH-1:0] aluResult,
    output logic [`DATA_WIDTH-1:0] newPc,
    output logic                   jumpOrBranch
);
    import pipelinePkg::*;

    logic [`DATA_WIDTH-1:0] operandB;
    logic [`DATA_WIDTH-1:0] branchTarget;
    logic                   aluZero;

    assign operandB = ctrlAluSrc ? immediate : readData2;

    always_comb
    begin
        case (aluOp)
            ALU_ADD:
            begin
                aluResult = readData1 + operandB;
            end
            ALU_SUB:
            begin
                aluResult = readData1 - operandB;
            end
            ALU_AND:
            begin
                aluResult = readData1 & operandB;
            end
            ALU_OR:
            begin
                aluResult = readData1 | operandB;
            end
            ALU_XOR:
            begin
                aluResult = readData1 ^ operandB;
            end
            ALU_SLT:
            begin
                aluResult = {{(`DATA_WIDTH-1){1'b0}},
                             $signed(readData1) < $signed(operandB)};
            end
            ALU_SLL:
            begin
                aluResult = readData1 << operandB[4:0];
            end
            default:
            begin
                aluResult = '0;
            end
        endcase
    end

    assign aluZero = (aluResult == '0);

    // branch offset is a word count relative to the next instruction.
    assign branchTarget = pc4 + (immediate << 2);

    // beq compares through the ALU, so a zero result means the operands were equal.
    assign jumpOrBranch = ctrlJump | (ctrlBranch & aluZero);
    assign newPc        = ctrlJump ? jumpTarget : branchTarget;

endmodule

/* verilog/exMemPipelineRegister.sv */
`timescale 1ns/1ps
`include "pipeline_consts.svh"

module exMemPipelineRegister
(
    input  logic                      clk,
    input  logic                      reset,

    input  logic [`DATA_WIDTH-1:0]     aluResultIn,
    input  logic [`DATA_WIDTH-1:0]     writeDataIn,
    input  logic [`DATA_WIDTH-1:0]     pc4In,
    input  logic [`REG_ADDR_WIDTH-1:0] writeRegisterIn,
    input  logic [`DATA_WIDTH-1:0]     newPcIn,
    input  logic                      jumpOrBranchIn,
    input  logic                      regWriteIn,
    input  logic                      memReadIn,
    input  logic                      memWriteIn,
    input  pipelinePkg::wbSource_t    wbSourceIn,

    output logic [`DATA_WIDTH-1:0]     aluResultOut,
    output logic [`DATA_WIDTH-1:0]     writeDataOut,
    output logic [`DATA_WIDTH-1:0]     pc4Out,
    output logic [`REG_ADDR_WIDTH-1:0] writeRegisterOut,
    output logic [`DATA_WIDTH-1:0]     newPcOut,
    output logic                      jumpOrBranchOut,
    output logic                      regWriteOut,
    output logic                      memReadOut,
    output logic                      memWriteOut,
    output pipelinePkg::wbSource_t    wbSourceOut
);
    import pipelinePkg::*;

    // the pipeline never stalls, so every field loads on each edge.
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            aluResultOut     <= '0;
            writeDataOut     <= '0;
            pc4Out           <= '0;
            writeRegisterOut <= '0;
            newPcOut         <= '0;
            jumpOrBranchOut  <= 1'b0;
            regWriteOut      <= 1'b0;
            memReadOut       <= 1'b0;
            memWriteOut      <= 1'b0;
            wbSourceOut      <= WB_ALU;
        end
        else
        begin
            aluResultOut     <= aluResultIn;
            writeDataOut     <= writeDataIn; // store data from the second register operand.
            pc4Out           <= pc4In;
            writeRegisterOut <= writeRegisterIn;
            newPcOut         <= newPcIn;
            jumpOrBranchOut  <= jumpOrBranchIn;
            regWriteOut      <= regWriteIn;
            memReadOut       <= memReadIn;
            memWriteOut      <= memWriteIn;
            wbSourceOut      <= wbSourceIn;
        end
    end

endmodule

/* verilog/memoryStage.sv */
`timescale 1ns/1ps
`include "pipeline_consts.svh"

module memoryStage
(
    input  logic                   clk,
    input  logic [`DATA_WIDTH-1:0] address,
    input  logic [`DATA_WIDTH-1:0] writeData,
    input  logic                   memRead,
    input  logic                   memWrite,
    output logic [`DATA_WIDTH-1:0] loadData
);
    logic [`DATA_WIDTH-1:0]      dataMemory [`DMEM_DEPTH];
    logic [`DMEM_ADDR_WIDTH-1:0] wordAddress;

    // byte address to word index. bits 1:0 select a byte and are ignored.
    assign wordAddress = address[`DMEM_ADDR_WIDTH+1:2];

    always_ff @(posedge clk)
    begin
        if (memWrite)
        begin
            dataMemory[wordAddress] <= writeData;
        end
    end

    // a load sees the array as it stands before the next edge.
    assign loadData = memRead ? dataMemory[wordAddress] : '0;

endmodule

/* verilog/writebackStage.sv */
`timescale 1ns/1ps
`include "pipeline_consts.svh"

module writebackStage
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`DATA_WIDTH-1:0]     aluResult,
    input  logic [`DATA_WIDTH-1:0]     loadData,
    input  logic [`DATA_WIDTH-1:0]     pc4,
    input  logic [`REG_ADDR_WIDTH-1:0] writeRegister,
    input  logic                      regWrite,
    input  pipelinePkg::wbSource_t    wbSource,
    output logic                      wbRegWrite,
    output logic [`REG_ADDR_WIDTH-1:0] wbWriteRegister,
    output logic [`DATA_WIDTH-1:0]     wbWriteData
);
    import pipelinePkg::*;

    logic [`DATA_WIDTH-1:0] aluResultQ;
    logic [`DATA_WIDTH-1:0] loadDataQ;
    logic [`DATA_WIDTH-1:0] pc4Q;
    logic                   regWriteQ;
    wbSource_t              wbSourceQ;

    // MEM/WB register.
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            aluResultQ      <= '0;
            loadDataQ       <= '0;
            pc4Q            <= '0;
            wbWriteRegister <= '0;
            regWriteQ       <= 1'b0;
            wbSourceQ       <= WB_ALU;
        end
        else
        begin
            aluResultQ      <= aluResult;
            loadDataQ       <= loadData;
            pc4Q            <= pc4;
            wbWriteRegister <= writeRegister;
            regWriteQ       <= regWrite;
            wbSourceQ       <= wbSource;
        end
    end

    always_comb
    begin
        case (wbSourceQ)
            WB_MEM:  wbWriteData = loadDataQ;
            WB_PC4:  wbWriteData = pc4Q; // return address of a jump-and-link.
            default: wbWriteData = aluResultQ;
        endcase
    end

    // register 0 is hardwired to zero, so writes to it are dropped here.
    assign wbRegWrite = regWriteQ & (wbWriteRegister != '0);

endmodule

/* verilog/backEndPipeline.sv */
`timescale 1ns/1ps
`include "pipeline_consts.svh"

module backEndPipeline
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`DATA_WIDTH-1:0]     readData1,
    input  logic [`DATA_WIDTH-1:0]     readData2,
    input  logic [`DATA_WIDTH-1:0]     immediate,
    input  logic                      ctrlAluSrc,
    input  pipelinePkg::aluOp_t       aluOp,
    input  logic [`DATA_WIDTH-1:0]     pc4,
    input  logic [`DATA_WIDTH-1:0]     jumpTarget,
    input  logic [`REG_ADDR_WIDTH-1:0] writeRegister,
    input  logic                      ctrlBranch,
    input  logic                      ctrlJump,
    input  logic                      ctrlRegWrite,
    input  logic                      ctrlMemRead,
    input  logic                      ctrlMemWrite,
    input  pipelinePkg::wbSource_t    wbSource,
    output logic                      branchTaken,
    output logic [`DATA_WIDTH-1:0]     branchTarget,
    output logic                      wbRegWrite,
    output logic [`REG_ADDR_WIDTH-1:0] wbWriteRegister,
    output logic [`DATA_WIDTH-1:0]     wbWriteData
);
    import pipelinePkg::*;

    logic [`DATA_WIDTH-1:0]     exAluResult;
    logic [`DATA_WIDTH-1:0]     exNewPc;
    logic                      exJumpOrBranch;

    logic [`DATA_WIDTH-1:0]     memAluResult;
    logic [`DATA_WIDTH-1:0]     memWriteData;
    logic [`DATA_WIDTH-1:0]     memPc4;
    logic [`REG_ADDR_WIDTH-1:0] memWriteRegister;
    logic                      memRegWrite;
    logic                      memMemRead;
    logic                      memMemWrite;
    wbSource_t                 memWbSource;
    logic [`DATA_WIDTH-1:0]     memLoadData;

    executeStage execute
    (
        .readData1    (readData1),
        .readData2    (readData2),
        .immediate    (immediate),
        .pc4          (pc4),
        .jumpTarget   (jumpTarget),
        .ctrlAluSrc   (ctrlAluSrc),
        .ctrlBranch   (ctrlBranch),
        .ctrlJump     (ctrlJump),
        .aluOp        (aluOp),
        .aluResult    (exAluResult),
        .newPc        (exNewPc),
        .jumpOrBranch (exJumpOrBranch)
    );

    // the redirect leaves straight from the EX/MEM register.
    exMemPipelineRegister exMem
    (
        .clk              (clk),
        .reset            (reset),
        .aluResultIn      (exAluResult),
        .writeDataIn      (readData2),
        .pc4In            (pc4),
        .writeRegisterIn  (writeRegister),
        .newPcIn          (exNewPc),
        .jumpOrBranchIn   (exJumpOrBranch),
        .regWriteIn       (ctrlRegWrite),
        .memReadIn        (ctrlMemRead),
        .memWriteIn       (ctrlMemWrite),
        .wbSourceIn       (wbSource),
        .aluResultOut     (memAluResult),
        .writeDataOut     (memWriteData),
        .pc4Out           (memPc4),
        .writeRegisterOut (memWriteRegister),
        .newPcOut         (branchTarget),
        .jumpOrBranchOut  (branchTaken),
        .regWriteOut      (memRegWrite),
        .memReadOut       (memMemRead),
        .memWriteOut      (memMemWrite),
        .wbSourceOut      (memWbSource)
    );

    memoryStage memory
    (
        .clk       (clk),
        .address   (memAluResult),
        .writeData (memWriteData),
        .memRead   (memMemRead),
        .memWrite  (memMemWrite),
        .loadData  (memLoadData)
    );

    writebackStage writeback
    (
        .clk             (clk),
        .reset           (reset),
        .aluResult       (memAluResult),
        .loadData        (memLoadData),
        .pc4             (memPc4),
        .writeRegister   (memWriteRegister),
        .regWrite        (memRegWrite),
        .wbSource        (memWbSource),
        .wbRegWrite      (wbRegWrite),
        .wbWriteRegister (wbWriteRegister),
        .wbWriteData     (wbWriteData)
    );

endmodule

/* tb/backEndPipeline_tb.sv */
`timescale 1ns/1ps
`include "pipeline_consts.svh"

module backEndPipeline_tb;
    import pipelinePkg::*;

    typedef struct packed
    {
        logic [`DATA_WIDTH-1:0]     readData1;
        logic [`DATA_WIDTH-1:0]     readData2;
        logic [`DATA_WIDTH-1:0]     immediate;
        logic [`DATA_WIDTH-1:0]     pc4;
        logic [`DATA_WIDTH-1:0]     jumpTarget;
        logic [`REG_ADDR_WIDTH-1:0] writeRegister;
        aluOp_t                     aluOp;
        wbSource_t                  wbSource;
        logic                       aluSrc;
        logic                       branch;
        logic                       jump;
        logic                       regWrite;
        logic                       memRead;
        logic                       memWrite;
    } instr_t;

    typedef struct packed
    {
        logic                       taken;
        logic [`DATA_WIDTH-1:0]     target;
        logic                       regWrite;
        logic [`REG_ADDR_WIDTH-1:0] writeRegister;
        logic [`DATA_WIDTH-1:0]     writeData;
    } expect_t;

    logic                        clk = 1'b0;
    logic                        reset;
    instr_t                      current; // instruction on the DUT inputs.
    logic                        branchTaken;
    logic [`DATA_WIDTH-1:0]      branchTarget;
    logic                        wbRegWrite;
    logic [`REG_ADDR_WIDTH-1:0]  wbWriteRegister;
    logic [`DATA_WIDTH-1:0]      wbWriteData;
    expect_t                     pendingExp;
    expect_t                     expQueue[$];
    logic [`DATA_WIDTH-1:0]      modelMemory [`DMEM_DEPTH];
    logic [`DMEM_ADDR_WIDTH-1:0] writtenAddrs[$];
    integer                      seed;
    integer                      errorCount;
    integer                      checkCount;
    integer                      wbChecks;
    logic                        timedOut;

    backEndPipeline UUT
    (
        .clk             (clk),
        .reset           (reset),
        .readData1       (current.readData1),
        .readData2       (current.readData2),
        .immediate       (current.immediate),
        .ctrlAluSrc      (current.aluSrc),
        .aluOp           (current.aluOp),
        .pc4             (current.pc4),
        .jumpTarget      (current.jumpTarget),
        .writeRegister   (current.writeRegister),
        .ctrlBranch      (current.branch),
        .ctrlJump        (current.jump),
        .ctrlRegWrite    (current.regWrite),
        .ctrlMemRead     (current.memRead),
        .ctrlMemWrite    (current.memWrite),
        .wbSource        (current.wbSource),
        .branchTaken     (branchTaken),
        .branchTarget    (branchTarget),
        .wbRegWrite      (wbRegWrite),
        .wbWriteRegister (wbWriteRegister),
        .wbWriteData     (wbWriteData)
    );

    always #50 clk = ~clk;

    initial
    begin
        reset = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b1;
    end

    function automatic logic [`DATA_WIDTH-1:0] randomWord();
        randomWord = $random(seed);
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] aluModel(input instr_t ins);
        logic [`DATA_WIDTH-1:0] b;
        b = ins.aluSrc ? ins.immediate : ins.readData2;
        case (ins.aluOp)
            ALU_ADD: aluModel = ins.readData1 + b;
            ALU_SUB: aluModel = ins.readData1 - b;
            ALU_AND: aluModel = ins.readData1 & b;
            ALU_OR:  aluModel = ins.readData1 | b;
            ALU_XOR: aluModel = ins.readData1 ^ b;
            ALU_SLT: aluModel = ($signed(ins.readData1) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLL: aluModel = ins.readData1 << b[4:0];
            default: aluModel = '0;
        endcase
    endfunction

    function automatic expect_t referenceModel(input instr_t ins,
                                               input logic [`DATA_WIDTH-1:0] memory [`DMEM_DEPTH]);
        logic [`DATA_WIDTH-1:0] alu;
        expect_t                e;
        alu = aluModel(ins);
        e.taken = ins.jump | (ins.branch & (alu == '0));
        e.target = ins.jump ? ins.jumpTarget : ins.pc4 + (ins.immediate << 2);
        e.regWrite = ins.regWrite & (ins.writeRegister != '0); // $zero is never written.
        e.writeRegister = ins.writeRegister;
        case (ins.wbSource)
            WB_MEM:  e.writeData = ins.memRead ? memory[alu[`DMEM_ADDR_WIDTH+1:2]] : '0;
            WB_PC4:  e.writeData = ins.pc4;
            default: e.writeData = alu;
        endcase
        referenceModel = e;
    endfunction

    // kind 0 ALU, 1 store, 2 load, 3 branch, 4 jump-and-link, anything else a bubble.
    function automatic instr_t randomInstr(input integer kind);
        instr_t                 ins;
        logic [`DATA_WIDTH-1:0] r;
        logic [`DATA_WIDTH-1:0] address;
        r = randomWord();
        ins = '0;
        ins.readData1 = randomWord();
        ins.readData2 = randomWord();
        ins.immediate = randomWord();
        ins.pc4 = randomWord() & ~32'd3;
        ins.jumpTarget = randomWord() & ~32'd3;
        ins.writeRegister = r[4:0];
        ins.aluOp = aluOp_t'(r[7:5] % 3'd7);
        ins.aluSrc = r[8];
        case (kind)
            0: ins.regWrite = 1'b1;
            1, 2:
            begin
                address = randomWord();
                if (kind == 1)
                    address[`DMEM_ADDR_WIDTH+1:2] = r[16:9];
                else // often the word stored just before, so the load follows its store.
                    address[`DMEM_ADDR_WIDTH+1:2] = writtenAddrs[r[17] ? writtenAddrs.size() - 1
                                                    : r[31:20] % writtenAddrs.size()];
                ins.aluOp = ALU_ADD;
                ins.aluSrc = 1'b1;
                ins.readData1 = address - ins.immediate;
                ins.memWrite = (kind == 1);
                ins.memRead = (kind == 2);
                ins.regWrite = (kind == 2);
                ins.wbSource = (kind == 2) ? WB_MEM : WB_ALU;
            end
            3:
            begin
                ins.branch = 1'b1;
                ins.aluOp = ALU_SUB;
                ins.aluSrc = 1'b0;
                if (r[9])
                    ins.readData2 = ins.readData1; // equal operands take the branch.
            end
            4:
            begin
                ins.jump = 1'b1;
                ins.regWrite = 1'b1;
                ins.wbSource = WB_PC4;
            end
            default: ins.regWrite = 1'b0;
        endcase
        randomInstr = ins;
    endfunction

    task automatic issueInstruction(input instr_t ins);
        logic [`DATA_WIDTH-1:0] address;
        @(negedge clk);
        pendingExp = referenceModel(ins, modelMemory);
        address = aluModel(ins);
        if (ins.memWrite)
        begin
            modelMemory[address[`DMEM_ADDR_WIDTH+1:2]] = ins.readData2;
            writtenAddrs.push_back(address[`DMEM_ADDR_WIDTH+1:2]);
        end
        current = ins;
    endtask

    task automatic waitForReset();
        integer timer;
        timer = 0;
        while (reset !== 1'b1 && timer < 10)
        begin
            @(posedge clk);
            timer++;
        end
        if (reset !== 1'b1)
        begin
            $display("timeout: reset was still asserted after %0d cycles", timer);
            timedOut = 1'b1;
        end
    endtask

    // the last instruction still owes one writeback comparison.
    task automatic drainPipeline();
        integer timer;
        integer target;
        @(posedge clk);
        target = wbChecks + 1;
        timer = 0;
        while (wbChecks < target && timer < 10)
        begin
            @(posedge clk);
            timer++;
        end
        if (wbChecks < target)
        begin
            $display("timeout: the pipeline did not drain its last writeback");
            timedOut = 1'b1;
        end
    endtask

    // expQueue holds the instruction in EX/MEM at its back and the one in MEM/WB at its front.
    always
    begin
        @(posedge clk);
        if (reset)
            expQueue.push_back(pendingExp);
        else
            expQueue.push_back('0);
        if (expQueue.size() > 2)
            expQueue.delete(0);
        @(negedge clk);
        checkCount++;
        assert (branchTaken === expQueue[$].taken && branchTarget === expQueue[$].target)
        else
        begin
            errorCount++;
            $display("ERROR %0t: redirect %b %h, expected %b %h", $time, branchTaken,
                     branchTarget, expQueue[$].taken, expQueue[$].target);
        end
        if (expQueue.size() == 2)
        begin
            checkCount++;
            wbChecks++;
            assert ({wbRegWrite, wbWriteRegister, wbWriteData} === {expQueue[0].regWrite,
                    expQueue[0].writeRegister, expQueue[0].writeData})
            else
            begin
                errorCount++;
                $display("ERROR %0t: writeback %b r%0d %h, expected %b r%0d %h", $time,
                         wbRegWrite, wbWriteRegister, wbWriteData, expQueue[0].regWrite,
                         expQueue[0].writeRegister, expQueue[0].writeData);
            end
        end
    end

    initial
    begin
        instr_t ins;
        integer i;
        seed = 4861;
        errorCount = 0;
        checkCount = 0;
        wbChecks = 0;
        timedOut = 1'b0;
        // a live jump-and-link sits on the inputs through reset, so only the clear keeps outputs low.
        current = randomInstr(4);
        current.writeRegister = 5'd31;
        pendingExp = referenceModel(current, modelMemory);
        waitForReset();
        if (!timedOut)
        begin
            for (i = 0; i < 56; i++)
            begin
                ins = randomInstr(0);
                ins.aluOp = aluOp_t'(i[3:1] % 3'd7);
                ins.aluSrc = i[0];
                if (i < 2)
                    ins.writeRegister = '0;
                issueInstruction(ins);
            end
            for (i = 0; i < 32; i++)
                issueInstruction(randomInstr(1 + i % 2));
            for (i = 0; i < 20; i++)
                issueInstruction(randomInstr(3 + i % 2));
            // first half back to back, second half with bubbles mixed in.
            for (i = 0; i < 300; i++)
                issueInstruction(randomInstr(randomWord() % (i < 150 ? 5 : 6)));
            issueInstruction(randomInstr(5));
            drainPipeline();
        end
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0 && !timedOut)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* backEndPipeline.f */
+incdir+verilog
verilog/pipelinePkg.sv
verilog/executeStage.sv
verilog/exMemPipelineRegister.sv
verilog/memoryStage.sv
verilog/writebackStage.sv
verilog/backEndPipeline.sv
tb/backEndPipeline_tb.sv

/* runSim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module backEndPipeline_tb -f backEndPipeline.f -o backEndSim
./obj_dir/backEndSim | tee sim.log

if grep -qx "TEST PASSED" sim.log
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
